// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= acq_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
source/acq_pkg.sv
source/sample_timer.sv
source/preamp_spi.sv
source/adc_spi.sv
source/acq_ctrl.sv
source/acq_top.sv
dv/acq_properties.sv
dv/acq_tb.sv

// ==== dv/acq_properties.sv ====
`timescale 1ns/10ps

module acq_props (
	input logic CLK50MHZ,
	input logic RST,
	input logic amp_cs_n,
	input logic ad_conv,
	input logic amp_trig,
	input logic amp_done
);

	// Set once the gain write has finished
	logic amp_seen;

	// Number of assertion failures so far
	int fail_count = 0;

	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			amp_seen <= 1'b0;
		else if (amp_done)
			amp_seen <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus sharing and sequencing
	//////////////////////////////////////////////////////////////////////

	// Preamp select and convert strobe never overlap
	bus_exclusive: assert property (@(posedge CLK50MHZ) disable iff (RST)
		!(!amp_cs_n && ad_conv))
		else begin
			$error("amp_cs_n low while ad_conv is high");
			fail_count++;
		end

	// Convert strobe is a single clock
	conv_one_cycle: assert property (@(posedge CLK50MHZ) disable iff (RST)
		ad_conv |=> !ad_conv)
		else begin
			$error("ad_conv stayed high for more than one cycle");
			fail_count++;
		end

	// No conversion before the gains are written
	conv_after_gain: assert property (@(posedge CLK50MHZ) disable iff (RST)
		ad_conv |-> amp_seen)
		else begin
			$error("ad_conv pulsed before the first amp_done");
			fail_count++;
		end

	// Gain write requested only right after reset
	trig_after_reset: assert property (@(posedge CLK50MHZ) disable iff (RST)
		amp_trig |-> $past(RST))
		else begin
			$error("amp_trig high outside the first cycle after reset");
			fail_count++;
		end

endmodule

bind acq_top acq_props u_acq_props (
	.CLK50MHZ(CLK50MHZ), .RST(RST), .amp_cs_n(amp_cs_n), .ad_conv(ad_conv),
	.amp_trig(amp_trig), .amp_done(amp_done)
);

// ==== dv/acq_tb.sv ====
`timescale 1ns/10ps

module acq_tb;

	import acq_pkg::*;

	localparam int SAMPLE_PERIOD = 200;
	localparam int SPI_DIV = 2;
	localparam gain_code_t GAIN_A = 4'd9;
	localparam gain_code_t GAIN_B = 4'd9;
	localparam int NUM_CONV = 21;
	// Cycles per conversion from timer, ADC frame and sequencer overhead
	localparam int CONV_CYCLES = SAMPLE_PERIOD + ADC_FRAME_BITS * 2 * SPI_DIV + 10;
	// Extra cycles cover reset and the gain write
	localparam int CYCLE_LIMIT = NUM_CONV * CONV_CYCLES + 500;
	// Switch codes outside the data selections
	localparam logic [3:0] IDLE_SW [6] = '{4'h0, 4'h5, 4'h6, 4'h7, 4'hc, 4'hf};

	logic        CLK50MHZ;
	logic        RST;
	logic [3:0]  sw;
	logic [7:0]  led;
	logic        spi_sck;
	logic        spi_mosi;
	logic        amp_cs_n;
	logic        amp_miso = 1'b1;
	logic        ad_conv;
	logic        adc_miso = 1'b0;

	// Device model state
	logic [31:0]               rng_state = 32'd47455;
	adc_pair_t                 cur_pair;
	adc_pair_t                 adc_pairs[$];
	logic [ADC_FRAME_BITS-1:0] frame_sr = '0;
	int                        adc_falls = 0;
	logic                      adc_active = 1'b0;
	logic                      sck_last = 1'b0;
	logic [7:0]                amp_rx = '0;
	int                        amp_bits = 0;

	// Bookkeeping
	int         cycle_cnt = 0;
	int         errors = 0;
	int         tests_run = 0;
	int         tests_failed = 0;
	int         conv_count = 0;
	logic [7:0] led_hold = 8'haa;

	acq_top #(
		.SAMPLE_PERIOD(SAMPLE_PERIOD), .SPI_DIV(SPI_DIV),
		.AMP_GAIN_A(GAIN_A), .AMP_GAIN_B(GAIN_B)
	) dut (.*);

	always #10 CLK50MHZ = ~CLK50MHZ;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Whole ADC frame with the first SCK bit in the MSB
	function automatic logic [ADC_FRAME_BITS-1:0] adc_frame(input adc_pair_t p);
		logic [ADC_FRAME_BITS-1:0] f;
		f = ADC_FRAME_BITS'($unsigned(p.a)) << (ADC_FRAME_BITS - ADC_A_FIRST - 14);
		f = f | (ADC_FRAME_BITS'($unsigned(p.b)) << (ADC_FRAME_BITS - ADC_B_FIRST - 14));
		return f;
	endfunction

	// LED byte the board should show for a switch code
	function automatic logic [7:0] expected_led(input logic [3:0] sel, input adc_pair_t p,
		input int conv_num);
		case (sel)
			4'h1: return p.a[7:0];
			4'h2: return {2'b00, p.a[13:8]};
			4'h4: return p.b[7:0];
			4'h8: return {2'b00, p.b[13:8]};
			// Preamp model answers with all ones
			4'h3: return 8'hff;
			// One tick per conversion and the toggle starts at zero
			default: return {7'h55, conv_num[0]};
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Preamplifier and ADC models
	//////////////////////////////////////////////////////////////////////

	always @(negedge CLK50MHZ) begin
		// Preamp shifts MOSI in on SCK rise
		if (!amp_cs_n && spi_sck && !sck_last) begin
			amp_rx = {amp_rx[6:0], spi_mosi};
			amp_bits = amp_bits + 1;
		end
		// New random pair on every convert strobe
		if (ad_conv) begin
			rng_state = xorshift(rng_state);
			cur_pair.a = rng_state[13:0];
			cur_pair.b = rng_state[29:16];
			adc_pairs.push_back(cur_pair);
			frame_sr = adc_frame(cur_pair);
			adc_falls = 0;
			adc_active = 1'b1;
		end else if (adc_active && !spi_sck && sck_last) begin
			// Next bit after each SCK fall
			frame_sr = frame_sr << 1;
			adc_falls = adc_falls + 1;
			if (adc_falls == ADC_FRAME_BITS)
				adc_active = 1'b0;
		end
		adc_miso <= adc_active ? frame_sr[ADC_FRAME_BITS-1] : 1'b0;
		sck_last = spi_sck;
	end

	// Watchdog
	always @(posedge CLK50MHZ) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Select a byte, wait for one conversion and check the LEDs
	task automatic check_conversion(input logic [3:0] sel);
		logic [7:0] exp;
		sw = sel;
		do begin
			@(negedge CLK50MHZ);
			assert (led == led_hold) else begin
				$display("MISMATCH at %0t ns: led %h changed to %h before adc_done",
					$time, led_hold, led);
				errors++;
			end
		end while (!dut.adc_done);
		@(negedge CLK50MHZ);
		conv_count++;
		assert (adc_pairs.size() == conv_count) else begin
			$display("ADC model saw %0d convert pulses in %0d conversions",
				adc_pairs.size(), conv_count);
			errors++;
		end
		exp = expected_led(sel, adc_pairs[$], conv_count);
		assert (led == exp) else begin
			$display("MISMATCH at %0t ns: sw %h led %h expected %h", $time, sel, led, exp);
			errors++;
		end
		led_hold = exp;
	endtask

	task automatic report_test(input string name, input int errors_before, input int n);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok, %0d conversions", name, n);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	initial begin
		int          mark;
		logic [31:0] pick;
		CLK50MHZ = 1'b0;
		RST = 1'b1;
		sw = 4'h3;
		pick = 32'd47455;
		repeat (5) @(negedge CLK50MHZ);
		RST = 1'b0;

		// Idle outputs straight after reset
		mark = errors;
		assert (led == 8'haa && amp_cs_n && !ad_conv && !spi_sck) else begin
			$display("MISMATCH at %0t ns: after reset led %h cs_n %b conv %b sck %b",
				$time, led, amp_cs_n, ad_conv, spi_sck);
			errors++;
		end
		report_test("reset_state", mark, 0);

		// Gain word B then A and readback on sw 3
		mark = errors;
		while (amp_cs_n)
			@(negedge CLK50MHZ);
		while (!amp_cs_n)
			@(negedge CLK50MHZ);
		assert (amp_bits == 8) else begin
			$display("Preamplifier model saw %0d SCK rises instead of 8", amp_bits);
			errors++;
		end
		assert (amp_rx == {GAIN_B, GAIN_A}) else begin
			$display("MISMATCH at %0t ns: gain word %h expected %h", $time, amp_rx,
				{GAIN_B, GAIN_A});
			errors++;
		end
		check_conversion(4'h3);
		report_test("gain_write", mark, 1);

		// Channel bytes over sw 1, 2, 4 and 8
		mark = errors;
		for (int i = 0; i < 8; i++)
			check_conversion(4'(1 << (i % 4)));
		report_test("channel_bytes", mark, 8);

		// Idle pattern with the alternating tick bit
		mark = errors;
		for (int i = 0; i < 6; i++)
			check_conversion(IDLE_SW[i]);
		report_test("idle_pattern", mark, 6);

		// Random switch codes
		mark = errors;
		for (int i = 0; i < 6; i++) begin
			pick = xorshift(pick);
			check_conversion(pick[7:4]);
		end
		report_test("random_mix", mark, 6);

		// Bound checker failures over the whole run
		mark = errors;
		errors += dut.u_acq_props.fail_count;
		report_test("bound_properties", mark, conv_count);

		$display("%0d tests, %0d failed, %0d errors, %0d conversions",
			tests_run, tests_failed, errors, conv_count);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== source/acq_ctrl.sv ====
`timescale 1ns/10ps

module acq_ctrl #(
	parameter int SAMPLE_PERIOD = 5_000_000
) (
	input  logic               CLK50MHZ,
	input  logic               RST,
	// Preamplifier worker
	output logic               amp_trig,
	input  logic               amp_done,
	input  logic [7:0]         amp_readback,
	// ADC worker
	output logic               adc_trig,
	input  logic               adc_done,
	input  acq_pkg::adc_pair_t adc_data,
	// Board controls
	input  logic [3:0]         sw,
	output logic [7:0]         led
);

	import acq_pkg::*;

	acq_state_t state;
	logic       cnt_en;
	logic       cnt_trig;
	logic       tick_toggle;

	// Sample period timer
	sample_timer #(
		.SAMPLE_PERIOD(SAMPLE_PERIOD)
	) u_sample_timer (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.cnt_en(cnt_en),
		.cnt_trig(cnt_trig)
	);

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= restart;
		end else begin
			case (state)
				restart:        state <= amp_sending;
				amp_sending:    if (amp_done) state <= cnt_start;
				cnt_start:      state <= cnt_wait;
				cnt_wait:       if (cnt_trig) state <= adc_convert;
				adc_convert:    state <= adc_converting;
				adc_converting: if (adc_done) state <= cnt_start;
				default:        state <= restart;
			endcase
		end
	end

	// Gain write only once, in restart
	assign amp_trig = (state == restart);

	// Convert request one cycle after the tick
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			adc_trig <= 1'b0;
		else
			adc_trig <= (state == cnt_wait) && cnt_trig;
	end

	// Timer runs from cnt_start up to its tick
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			cnt_en <= 1'b0;
		else if (state == cnt_start)
			cnt_en <= 1'b1;
		else if (state == cnt_wait && cnt_trig)
			cnt_en <= 1'b0;
	end

	// Heartbeat bit for the idle pattern
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			tick_toggle <= 1'b0;
		else if (cnt_trig)
			tick_toggle <= ~tick_toggle;
	end

	//////////////////////////////////////////////////////////////////////
	// LED display
	//////////////////////////////////////////////////////////////////////

	// Loaded only with a fresh conversion
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			led <= LED_RESET_PATTERN;
		end else if (adc_done) begin
			case (sw)
				4'h1:    led <= adc_data.a[7:0];
				4'h2:    led <= {2'b00, adc_data.a[13:8]};
				4'h4:    led <= adc_data.b[7:0];
				4'h8:    led <= {2'b00, adc_data.b[13:8]};
				4'h3:    led <= amp_readback;
				default: led <= {LED_IDLE_BASE, tick_toggle};
			endcase
		end
	end

endmodule

// ==== source/acq_pkg.sv ====
package acq_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data types
	//////////////////////////////////////////////////////////////////////

	// One ADC channel, two's complement
	typedef logic signed [13:0] adc_sample_t;

	// Preamplifier gain code, one per channel
	typedef logic [3:0] gain_code_t;

	// Complete conversion result, channel a in the upper half
	typedef struct packed {
		adc_sample_t a;
		adc_sample_t b;
	} adc_pair_t;

	// Sequencer states
	typedef enum logic [2:0] {
		restart,
		amp_sending,
		cnt_start,
		cnt_wait,
		adc_convert,
		adc_converting
	} acq_state_t;

	//////////////////////////////////////////////////////////////////////
	// SPI framing
	//////////////////////////////////////////////////////////////////////

	// SCK cycles in one ADC frame
	localparam int ADC_FRAME_BITS = 34;

	// First SCK index of each channel, 14 bits MSB first
	localparam int ADC_A_FIRST = 2;
	localparam int ADC_B_FIRST = 18;

	// LED values
	localparam logic [7:0] LED_RESET_PATTERN = 8'haa;
	localparam logic [6:0] LED_IDLE_BASE = 7'h55;

endpackage

// ==== source/acq_top.sv ====
`timescale 1ns/10ps

module acq_top #(
	parameter int                  SAMPLE_PERIOD = 5_000_000,
	parameter int                  SPI_DIV       = 4,
	parameter acq_pkg::gain_code_t AMP_GAIN_A    = 4'd9,
	parameter acq_pkg::gain_code_t AMP_GAIN_B    = 4'd9
) (
	input  logic       CLK50MHZ,
	input  logic       RST,
	input  logic [3:0] sw,
	output logic [7:0] led,
	// Shared SPI bus
	output logic       spi_sck,
	output logic       spi_mosi,
	// Preamplifier
	output logic       amp_cs_n,
	input  logic       amp_miso,
	// ADC
	output logic       ad_conv,
	input  logic       adc_miso
);

	import acq_pkg::*;

	logic       amp_trig;
	logic       amp_done;
	logic [7:0] amp_readback;
	logic       amp_sck;
	logic       amp_mosi;
	logic       adc_trig;
	logic       adc_done;
	adc_pair_t  adc_data;
	logic       adc_sck;

	acq_ctrl #(
		.SAMPLE_PERIOD(SAMPLE_PERIOD)
	) u_acq_ctrl (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.amp_trig(amp_trig), .amp_done(amp_done), .amp_readback(amp_readback),
		.adc_trig(adc_trig), .adc_done(adc_done), .adc_data(adc_data),
		.sw(sw), .led(led)
	);

	preamp_spi #(
		.SPI_DIV(SPI_DIV), .AMP_GAIN_A(AMP_GAIN_A), .AMP_GAIN_B(AMP_GAIN_B)
	) u_preamp_spi (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.amp_trig(amp_trig), .amp_done(amp_done), .amp_readback(amp_readback),
		.amp_cs_n(amp_cs_n), .sck(amp_sck), .mosi(amp_mosi), .amp_miso(amp_miso)
	);

	adc_spi #(
		.SPI_DIV(SPI_DIV)
	) u_adc_spi (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.adc_trig(adc_trig), .adc_done(adc_done), .adc_data(adc_data),
		.ad_conv(ad_conv), .sck(adc_sck), .adc_miso(adc_miso)
	);

	// Idle engine holds SCK low, so OR is safe
	assign spi_sck = amp_sck | adc_sck;

	// MOSI belongs to the preamp only while selected
	assign spi_mosi = amp_cs_n ? 1'b0 : amp_mosi;

endmodule

// ==== source/adc_spi.sv ====
`timescale 1ns/10ps

module adc_spi #(
	parameter int SPI_DIV = 4
) (
	input  logic               CLK50MHZ,
	input  logic               RST,
	input  logic               adc_trig,
	output logic               adc_done,
	output acq_pkg::adc_pair_t adc_data,
	output logic               ad_conv,
	output logic               sck,
	input  logic               adc_miso
);

	import acq_pkg::*;

	localparam int CH_BITS = $bits(adc_sample_t);

	// SCK index within the frame
	localparam int BIT_W = $clog2(ADC_FRAME_BITS);
	typedef logic [BIT_W-1:0] bit_idx_t;

	localparam bit_idx_t LAST_BIT = BIT_W'(ADC_FRAME_BITS - 1);
	localparam bit_idx_t A_FIRST  = BIT_W'(ADC_A_FIRST);
	localparam bit_idx_t A_LAST   = BIT_W'(ADC_A_FIRST + CH_BITS - 1);
	localparam bit_idx_t B_FIRST  = BIT_W'(ADC_B_FIRST);
	localparam bit_idx_t B_LAST   = BIT_W'(ADC_B_FIRST + CH_BITS - 1);

	// SCK half period divider
	localparam int DIV_W = $clog2(SPI_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_DIV - 1);

	typedef enum logic [1:0] {
		conv_idle,
		conv_pulse,
		conv_shift
	} conv_state_t;

	conv_state_t      state;
	logic [DIV_W-1:0] div_cnt;
	logic             half_tick;
	bit_idx_t         bit_cnt;
	logic             sck_rise;
	logic             in_a;
	logic             in_b;

	assign half_tick = (div_cnt == DIV_LAST);
	assign sck_rise  = (state == conv_shift) && half_tick && !sck;

	// Which channel owns the current bit
	assign in_a = (bit_cnt >= A_FIRST) && (bit_cnt <= A_LAST);
	assign in_b = (bit_cnt >= B_FIRST) && (bit_cnt <= B_LAST);

	always_ff @(posedge CLK50MHZ) begin
		if (RST || state != conv_shift || half_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Convert pulse and frame
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= conv_idle;
			ad_conv  <= 1'b0;
			adc_done <= 1'b0;
			sck      <= 1'b0;
			bit_cnt  <= '0;
		end else begin
			adc_done <= 1'b0;
			case (state)
				conv_idle: begin
					if (adc_trig) begin
						ad_conv <= 1'b1;
						state   <= conv_pulse;
					end
				end
				conv_pulse: begin
					// Convert strobe is a single cycle
					ad_conv <= 1'b0;
					bit_cnt <= '0;
					state   <= conv_shift;
				end
				conv_shift: begin
					if (half_tick) begin
						sck <= ~sck;
						// ADC shifts on the fall, index advances here
						if (sck) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == LAST_BIT) begin
								adc_done <= 1'b1;
								state    <= conv_idle;
							end
						end
					end
				end
				default: state <= conv_idle;
			endcase
		end
	end

	// Bit k captured on the rise of SCK cycle k
	// Framing bits fall outside both windows
	always_ff @(posedge CLK50MHZ) begin
		if (sck_rise && in_a)
			adc_data.a <= {adc_data.a[CH_BITS-2:0], adc_miso};
		if (sck_rise && in_b)
			adc_data.b <= {adc_data.b[CH_BITS-2:0], adc_miso};
	end

endmodule

// ==== source/preamp_spi.sv ====
`timescale 1ns/10ps

module preamp_spi #(
	parameter int                  SPI_DIV    = 4,
	parameter acq_pkg::gain_code_t AMP_GAIN_A = 4'd9,
	parameter acq_pkg::gain_code_t AMP_GAIN_B = 4'd9
) (
	input  logic       CLK50MHZ,
	input  logic       RST,
	input  logic       amp_trig,
	output logic       amp_done,
	output logic [7:0] amp_readback,
	output logic       amp_cs_n,
	output logic       sck,
	output logic       mosi,
	input  logic       amp_miso
);

	// Gain word is B then A, one byte
	localparam int FRAME_BITS = 8;
	localparam int BIT_W = $clog2(FRAME_BITS);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_BITS - 1);

	// SCK half period divider
	localparam int DIV_W = $clog2(SPI_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_DIV - 1);

	typedef enum logic [1:0] {
		amp_idle,
		amp_shift,
		amp_trail
	} amp_state_t;

	amp_state_t       state;
	logic [DIV_W-1:0] div_cnt;
	logic             half_tick;
	logic [BIT_W-1:0] bit_cnt;
	logic [7:0]       tx_sr;
	logic [7:0]       rx_sr;

	assign half_tick = (div_cnt == DIV_LAST);

	// Divider only runs inside a frame
	always_ff @(posedge CLK50MHZ) begin
		if (RST || state == amp_idle || half_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Frame sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= amp_idle;
			amp_cs_n <= 1'b1;
			amp_done <= 1'b0;
			sck      <= 1'b0;
			bit_cnt  <= '0;
			tx_sr    <= '0;
		end else begin
			amp_done <= 1'b0;
			case (state)
				amp_idle: begin
					// Chip select falls, first bit goes out at once
					if (amp_trig) begin
						amp_cs_n <= 1'b0;
						tx_sr    <= {AMP_GAIN_B, AMP_GAIN_A};
						bit_cnt  <= '0;
						state    <= amp_shift;
					end
				end
				amp_shift: begin
					if (half_tick) begin
						sck <= ~sck;
						// Falling edge, next bit out
						if (sck) begin
							tx_sr   <= {tx_sr[6:0], 1'b0};
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == LAST_BIT)
								state <= amp_trail;
						end
					end
				end
				amp_trail: begin
					// Half period of hold before deselect
					if (half_tick) begin
						amp_cs_n <= 1'b1;
						amp_done <= 1'b1;
						state    <= amp_idle;
					end
				end
				default: state <= amp_idle;
			endcase
		end
	end

	// Readback sampled on SCK rise, stable until next frame
	always_ff @(posedge CLK50MHZ) begin
		if (state == amp_shift && half_tick && !sck)
			rx_sr <= {rx_sr[6:0], amp_miso};
	end

	// Shift register empties to zero after the last fall
	assign mosi = tx_sr[7];
	assign amp_readback = rx_sr;

endmodule

// ==== source/sample_timer.sv ====
`timescale 1ns/10ps

module sample_timer #(
	parameter int SAMPLE_PERIOD = 5_000_000
) (
	input  logic CLK50MHZ,
	input  logic RST,
	input  logic cnt_en,
	output logic cnt_trig
);

	// Counter wide enough for the full period
	localparam int CNT_W = $clog2(SAMPLE_PERIOD + 1);

	// Terminal count, one less than the period
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SAMPLE_PERIOD - 1);

	logic [CNT_W-1:0] cnt;

	// Counts from the cycle after enable rises
	// Tick lands exactly SAMPLE_PERIOD cycles later
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !cnt_en) begin
			// Held at zero while disabled
			cnt      <= '0;
			cnt_trig <= 1'b0;
		end else if (cnt == CNT_LAST) begin
			// Period reached, reload and pulse
			cnt      <= '0;
			cnt_trig <= 1'b1;
		end else begin
			cnt      <= cnt + 1'b1;
			cnt_trig <= 1'b0;
		end
	end

endmodule
